// ==== verilog/tx_fifo_cfg.svh ====
//*********************************************************************
// Size macros for the transmit dual-clock FIFO
//*********************************************************************
`ifndef TX_FIFO_CFG_SVH
`define TX_FIFO_CFG_SVH

// Data word
`define TX_FIFO_DWIDTH     20      // Bits per stored word

// Full-depth geometry
`define TX_FIFO_AWIDTH     4       // Slot index width
`define TX_FIFO_DEPTH      16      // Slots at PWR_FULL

// Smallest power-save geometry, PWR_HALF is twice this
`define TX_FIFO_PS_AWIDTH  2       // Slot index width, quarter mode
`define TX_FIFO_PS_DEPTH   4       // Slots at PWR_QUARTER

`endif

// ==== verilog/tx_fifo_pkg.sv ====
//*********************************************************************
// Power-mode enum, config/data structs and depth lookup
//*********************************************************************
`include "tx_fifo_cfg.svh"

package tx_fifo_pkg;

   localparam int unsigned PTR_W = `TX_FIFO_AWIDTH + 1;   // Pointer incl. wrap bit

   typedef logic [PTR_W-1:0]              tx_cnt_t;     // Pointers and counts
   typedef logic [`TX_FIFO_AWIDTH-1:0]    tx_ptr_t;     // Slot index
   typedef logic [`TX_FIFO_DWIDTH-1:0]    tx_word_t;    // One data word

   // Power mode opcode, picks the active depth
   typedef enum logic [1:0] {
      PWR_QUARTER = 2'd0,    // 4 entries
      PWR_HALF    = 2'd1,    // 8 entries
      PWR_FULL    = 2'd2     // 16 entries
   } pwr_mode_e;

   // Static config, only changed under reset
   typedef struct packed {
      pwr_mode_e pwr_mode;
      logic      stop_read;     // Block pops when empty
      logic      stop_write;    // Block pushes when full
      logic      double_write;  // Two words per push
   } tx_fifo_cfg_t;

   // Write payload, lo lands first
   typedef struct packed {
      tx_word_t hi;
      tx_word_t lo;
   } tx_dword_t;

   // Active depth for a power mode
   function automatic tx_cnt_t active_depth(input pwr_mode_e mode);
      case (mode)
         PWR_QUARTER: return tx_cnt_t'(`TX_FIFO_PS_DEPTH);
         PWR_HALF:    return tx_cnt_t'(1 << (`TX_FIFO_PS_AWIDTH + 1));
         default:     return tx_cnt_t'(`TX_FIFO_DEPTH);
      endcase
   endfunction

endpackage

// ==== verilog/cdc_bitsync2.sv ====
//*********************************************************************
// Two-flop synchronizer for a Gray-coded bus
//*********************************************************************
`timescale 1ns/10ps

module cdc_bitsync2 #(
   parameter int DWIDTH = 5               // Bus width
) (
   input  logic              clk,         // Destination clock
   input  logic              rst_n,       // Destination reset, sync
   input  logic [DWIDTH-1:0] data_in,     // Bus from other domain
   output logic [DWIDTH-1:0] data_out     // Bus, settled
);

   logic [DWIDTH-1:0] meta;               // First stage, may go metastable

   // Only one bit changes per step, so per-bit flops are safe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta     <= '0;
         data_out <= '0;
      end
      else begin
         meta     <= data_in;             // Capture
         data_out <= meta;                // Resolve
      end
   end

endmodule

// ==== verilog/tx_fifo_pointers.sv ====
//*********************************************************************
// Write/read pointers, Gray crossing and occupancy counts
//*********************************************************************
`timescale 1ns/10ps
`include "tx_fifo_cfg.svh"

module tx_fifo_pointers import tx_fifo_pkg::*; (
   input  logic         wr_clk,        // Write clock
   input  logic         wr_rst_n,      // Write reset, sync
   input  logic         rd_clk,        // Read clock
   input  logic         rd_rst_n,      // Read reset, sync
   input  logic         wr_en,         // Push request
   input  logic         rd_en,         // Pop request
   input  logic         wr_full,       // From flags
   input  logic         rd_empty,      // From flags
   input  tx_fifo_cfg_t cfg,
   output logic         wr_push,       // Memory store strobe
   output tx_ptr_t      wr_ptr_bin,    // Write slot
   output tx_ptr_t      rd_ptr_bin,    // Read slot
   output tx_cnt_t      wr_numdata,    // Count seen by write side
   output tx_cnt_t      rd_numdata     // Count seen by read side
);

   localparam int AW = `TX_FIFO_AWIDTH;
   localparam tx_cnt_t ONE = tx_cnt_t'(1);
   localparam tx_cnt_t TWO = tx_cnt_t'(2);

   tx_cnt_t wr_bin;         // Write pointer, binary
   tx_cnt_t wr_gry;         // Write pointer, Gray
   tx_cnt_t wr_bin_nxt;
   tx_cnt_t wr_gry_nxt;
   tx_cnt_t wr_step;        // 0, 1 or 2
   tx_cnt_t rd_bin;         // Read pointer, binary
   tx_cnt_t rd_gry;         // Read pointer, Gray
   tx_cnt_t rd_bin_nxt;
   tx_cnt_t rd_gry_nxt;
   logic    rd_pop;
   tx_cnt_t rd_gry_sync;    // Read Gray in write domain
   tx_cnt_t rd_bin_sync;
   tx_cnt_t wr_gry_sync;    // Write Gray in read domain
   tx_cnt_t wr_bin_sync;

   // Gray to binary; dw mode forces bit 0 low (pointer always even)
   function automatic tx_cnt_t gray2bin(input tx_cnt_t gry, input logic dw);
      tx_cnt_t bin;
      for (int i = 0; i <= AW; i++) begin
         bin[i] = ^(gry >> i);
      end
      if (dw) begin
         bin[0] = 1'b0;
      end
      return bin;
   endfunction

   assign wr_ptr_bin = wr_bin[AW-1:0];
   assign rd_ptr_bin = rd_bin[AW-1:0];

   //*****************************************************************
   // Write domain
   //*****************************************************************
   assign wr_push    = wr_en & ~(cfg.stop_write & wr_full);   // Drop when blocked
   assign wr_step    = !wr_push         ? '0  :
                       cfg.double_write ? TWO : ONE;
   assign wr_bin_nxt = wr_bin + wr_step;

   // Double mode encodes the halved pointer, LSB tied low
   assign wr_gry_nxt = cfg.double_write ?
                       {(wr_bin_nxt[AW:1] >> 1) ^ wr_bin_nxt[AW:1], 1'b0} :
                       (wr_bin_nxt >> 1) ^ wr_bin_nxt;

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin <= '0;
         wr_gry <= '0;
      end
      else begin
         wr_bin <= wr_bin_nxt;
         wr_gry <= wr_gry_nxt;
      end
   end

   // Read pointer into write clock
   cdc_bitsync2 #(
      .DWIDTH   (AW + 1)
   ) u_sync_rd2wr (
      .clk      (wr_clk),
      .rst_n    (wr_rst_n),
      .data_in  (rd_gry),
      .data_out (rd_gry_sync)
   );

   assign rd_bin_sync = gray2bin(rd_gry_sync, 1'b0);   // Read side steps by one
   assign wr_numdata  = wr_bin_nxt - rd_bin_sync;      // Next ptr, so flag is current

   //*****************************************************************
   // Read domain
   //*****************************************************************
   assign rd_pop     = rd_en & ~(cfg.stop_read & rd_empty);
   assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_pop};
   assign rd_gry_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin <= '0;
         rd_gry <= '0;
      end
      else begin
         rd_bin <= rd_bin_nxt;
         rd_gry <= rd_gry_nxt;
      end
   end

   // Write pointer into read clock
   cdc_bitsync2 #(
      .DWIDTH   (AW + 1)
   ) u_sync_wr2rd (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .data_in  (wr_gry),
      .data_out (wr_gry_sync)
   );

   assign wr_bin_sync = gray2bin(wr_gry_sync, cfg.double_write);   // Matching decode
   assign rd_numdata  = wr_bin_sync - rd_bin_nxt;

endmodule

// ==== verilog/tx_fifo_flags.sv ====
//*********************************************************************
// Registered full and empty flags
//*********************************************************************
`timescale 1ns/10ps

module tx_fifo_flags import tx_fifo_pkg::*; (
   input  logic         wr_clk,        // Write clock
   input  logic         wr_rst_n,      // Write reset, sync
   input  logic         rd_clk,        // Read clock
   input  logic         rd_rst_n,      // Read reset, sync
   input  tx_fifo_cfg_t cfg,
   input  tx_cnt_t      wr_numdata,    // Write-side count, next ptr
   input  tx_cnt_t      rd_numdata,    // Read-side count, next ptr
   output logic         wr_full,
   output logic         rd_empty
);

   tx_cnt_t depth;          // Active depth
   tx_cnt_t full_lvl;       // Count at which full rises

   assign depth = active_depth(cfg.pwr_mode);

   // A pair needs two free slots, so stop one short
   assign full_lvl = cfg.double_write ? depth - tx_cnt_t'(1) : depth;

   //*****************************************************************
   // Write domain
   //*****************************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_full <= 1'b0;                          // Not full out of reset
      end
      else begin
         wr_full <= (wr_numdata >= full_lvl);      // Stale read ptr only over-counts
      end
   end

   //*****************************************************************
   // Read domain
   //*****************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_empty <= 1'b1;                         // Empty out of reset
      end
      else begin
         rd_empty <= (rd_numdata == '0);           // Stale write ptr only under-counts
      end
   end

endmodule

// ==== verilog/tx_fifo_mem.sv ====
//*********************************************************************
// Register array, one-hot write decode and AND-OR read mux
//*********************************************************************
`timescale 1ns/10ps
`include "tx_fifo_cfg.svh"

module tx_fifo_mem import tx_fifo_pkg::*; (
   input  logic         wr_clk,        // Write clock
   input  logic         wr_rst_n,      // Write reset, sync
   input  logic         rd_clk,        // Read clock
   input  logic         wr_push,       // Store this cycle
   input  tx_dword_t    wr_data,       // lo, plus hi in double mode
   input  tx_ptr_t      wr_ptr_bin,
   input  tx_ptr_t      rd_ptr_bin,
   input  tx_fifo_cfg_t cfg,
   output tx_word_t     rd_data        // Show-ahead word
);

   localparam int DEPTH = `TX_FIFO_DEPTH;

   tx_word_t         mem [DEPTH];      // Storage, no reset
   tx_ptr_t          wr_mask;          // Index mask, write side
   tx_ptr_t          rd_mask;          // Same mask, retimed to rd_clk
   tx_ptr_t          wr_addr_hi;       // Pair slot
   logic [DEPTH-1:0] wr_oh_lo;
   logic [DEPTH-1:0] wr_oh_hi;
   logic [DEPTH-1:0] rd_oh;

   // Slot index to one-hot, held inside the active depth
   function automatic logic [DEPTH-1:0] to_onehot(input tx_ptr_t addr, input tx_ptr_t mask);
      logic [DEPTH-1:0] oh;
      oh              = '0;
      oh[addr & mask] = 1'b1;
      return oh;
   endfunction

   assign wr_mask = tx_ptr_t'(active_depth(cfg.pwr_mode) - tx_cnt_t'(1));

   // Config is static, local copy keeps the read path in one domain
   always_ff @(posedge rd_clk) begin
      rd_mask <= wr_mask;
   end

   //*****************************************************************
   // Write port
   //*****************************************************************
   assign wr_addr_hi = (wr_ptr_bin + tx_ptr_t'(1)) & wr_mask;   // Rotate in depth
   assign wr_oh_lo   = to_onehot(wr_ptr_bin, wr_mask);
   assign wr_oh_hi   = cfg.double_write ? to_onehot(wr_addr_hi, wr_mask) : '0;

   always_ff @(posedge wr_clk) begin
      if (wr_rst_n && wr_push) begin                        // Ignore pushes in reset
         for (int i = 0; i < DEPTH; i++) begin
            if (wr_oh_lo[i]) begin
               mem[i] <= wr_data.lo;
            end
            else if (wr_oh_hi[i]) begin
               mem[i] <= wr_data.hi;                        // Second word of pair
            end
         end
      end
   end

   //*****************************************************************
   // Read port
   //*****************************************************************
   assign rd_oh = to_onehot(rd_ptr_bin, rd_mask);

   always_comb begin
      rd_data = '0;
      for (int i = 0; i < DEPTH; i++) begin
         rd_data |= mem[i] & {`TX_FIFO_DWIDTH{rd_oh[i]}};   // AND-OR select
      end
   end

endmodule

// ==== verilog/tx_fifo_top.sv ====
//*********************************************************************
// Transmit dual-clock FIFO top
//*********************************************************************
`timescale 1ns/10ps

module tx_fifo_top import tx_fifo_pkg::*; (
   input  logic         wr_clk,        // Write clock
   input  logic         wr_rst_n,      // Write reset, sync
   input  logic         wr_en,         // Push
   input  tx_dword_t    wr_data,
   output logic         wr_full,
   input  logic         rd_clk,        // Read clock
   input  logic         rd_rst_n,      // Read reset, sync
   input  logic         rd_en,         // Pop
   output tx_word_t     rd_data,       // Show-ahead
   output logic         rd_empty,
   input  tx_fifo_cfg_t cfg            // Static config
);

   logic    wr_push;
   tx_ptr_t wr_ptr_bin;
   tx_ptr_t rd_ptr_bin;
   tx_cnt_t wr_numdata;
   tx_cnt_t rd_numdata;

   // Pointers and crossing
   tx_fifo_pointers u_tx_fifo_pointers (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .rd_clk     (rd_clk),
      .rd_rst_n   (rd_rst_n),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .wr_full    (wr_full),
      .rd_empty   (rd_empty),
      .cfg        (cfg),
      .wr_push    (wr_push),
      .wr_ptr_bin (wr_ptr_bin),
      .rd_ptr_bin (rd_ptr_bin),
      .wr_numdata (wr_numdata),
      .rd_numdata (rd_numdata)
   );

   // Full/empty
   tx_fifo_flags u_tx_fifo_flags (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .rd_clk     (rd_clk),
      .rd_rst_n   (rd_rst_n),
      .cfg        (cfg),
      .wr_numdata (wr_numdata),
      .rd_numdata (rd_numdata),
      .wr_full    (wr_full),
      .rd_empty   (rd_empty)
   );

   // Storage
   tx_fifo_mem u_tx_fifo_mem (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .rd_clk     (rd_clk),
      .wr_push    (wr_push),
      .wr_data    (wr_data),
      .wr_ptr_bin (wr_ptr_bin),
      .rd_ptr_bin (rd_ptr_bin),
      .cfg        (cfg),
      .rd_data    (rd_data)
   );

endmodule

// ==== test/tb_tx_fifo.sv ====
//*********************************************************************
// Directed testbench for the transmit dual-clock FIFO, queue model
//*********************************************************************
`timescale 1ns/10ps
`include "tx_fifo_cfg.svh"

module tb_tx_fifo import tx_fifo_pkg::*; ();

   localparam int WORD_ATTEMPTS = 140;                      // Write attempts, all tests
   localparam int WATCHDOG_NS   = WORD_ATTEMPTS * 20 * 140 + 100_000;
   localparam int EMPTY_WAIT    = 20;                       // Read cycles per word, max

   logic         wr_clk;
   logic         wr_rst_n;
   logic         wr_en;
   tx_dword_t    wr_data;
   logic         wr_full;
   logic         rd_clk;
   logic         rd_rst_n;
   logic         rd_en;
   tx_word_t     rd_data;
   logic         rd_empty;
   tx_fifo_cfg_t cfg;

   tx_word_t exp_q[$];     // Words written, not yet read
   int       accepted;     // Writes taken in last write_words
   int       mismatches;
   int       failures;
   logic     wr_done;      // Writer finished, interleaved test

   tx_fifo_top u_tx_fifo_top (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .wr_full  (wr_full),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .rd_empty (rd_empty),
      .cfg      (cfg)
   );

   // Read clock 100 ns
   initial begin
      rd_clk = 1'b0;
      forever #50 rd_clk = ~rd_clk;
   end

   // Write clock 140 ns, offset so rising edges never line up
   initial begin
      wr_clk = 1'b0;
      #30;
      forever #70 wr_clk = ~wr_clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired after %0d ns, a test never finished", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

   //*****************************************************************
   // Helpers
   //*****************************************************************
   task automatic note_mismatch(input string msg);
      mismatches++;
      $display("mismatch at %0d ns: %s", $time, msg);
   endtask

   task automatic note_failure(input string msg);
      failures++;
      $display("ERROR at %0d ns: %s", $time, msg);
   endtask

   // Both blocking modes on, only mode and pairing vary
   function automatic tx_fifo_cfg_t make_cfg(input pwr_mode_e mode, input logic dw);
      tx_fifo_cfg_t c;
      c.pwr_mode     = mode;
      c.stop_read    = 1'b1;
      c.stop_write   = 1'b1;
      c.double_write = dw;
      return c;
   endfunction

   task automatic apply_reset(input tx_fifo_cfg_t new_cfg);
      @(negedge wr_clk);
      wr_rst_n = 1'b0;
      wr_en    = 1'b0;
      @(negedge rd_clk);
      rd_rst_n = 1'b0;
      rd_en    = 1'b0;
      cfg      = new_cfg;                 // Both domains held here
      fork
         begin
            repeat (4) @(negedge wr_clk);
            wr_rst_n = 1'b1;
         end
         begin
            repeat (4) @(negedge rd_clk);
            rd_rst_n = 1'b1;
         end
      join
      exp_q.delete();
      @(negedge wr_clk);
      if (wr_full !== 1'b0) note_mismatch("wr_full not low after reset");
      @(negedge rd_clk);
      if (rd_empty !== 1'b1) note_mismatch("rd_empty not high after reset");
   endtask

   // Model takes the word when the DUT will, judged on wr_full
   task automatic write_words(input int n);
      accepted = 0;
      for (int i = 0; i < n; i++) begin
         @(negedge wr_clk);
         wr_data.lo = tx_word_t'($urandom);
         wr_data.hi = tx_word_t'($urandom);
         wr_en      = 1'b1;
         if (!(cfg.stop_write && wr_full)) begin
            accepted++;
            exp_q.push_back(wr_data.lo);
            if (cfg.double_write) exp_q.push_back(wr_data.hi);   // hi after lo
         end
      end
      @(negedge wr_clk);
      wr_en = 1'b0;
   endtask

   // Show-ahead, so check before the pop edge
   task automatic read_words(input int n);
      int waited;
      for (int i = 0; i < n; i++) begin
         @(negedge rd_clk);
         waited = 0;
         while (rd_empty && waited < EMPTY_WAIT) begin   // Crossing latency
            rd_en = 1'b0;
            @(negedge rd_clk);
            waited++;
         end
         if (rd_empty) begin
            rd_en = 1'b0;
            note_failure($sformatf("rd_empty stuck high with %0d words still due", n - i));
            return;
         end
         if (rd_data !== exp_q[0]) begin
            note_mismatch($sformatf("rd_data %0h, expected %0h", rd_data, exp_q[0]));
         end
         void'(exp_q.pop_front());
         rd_en = 1'b1;
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
   endtask

   task automatic drain_fifo();
      read_words(exp_q.size());
      if (rd_empty !== 1'b1) note_mismatch("rd_empty not high after drain");
      if (exp_q.size() != 0) note_failure("words left in the model after drain");
      repeat (4) @(negedge wr_clk);       // Read pointer reaches write side
   endtask

   //*****************************************************************
   // Tests
   //*****************************************************************
   task automatic ordered_transfer();
      apply_reset(make_cfg(PWR_FULL, 1'b0));
      write_words(12);
      if (accepted != 12) note_mismatch($sformatf("%0d of 12 writes taken", accepted));
      drain_fifo();
   endtask

   task automatic full_backpressure();
      apply_reset(make_cfg(PWR_FULL, 1'b0));
      write_words(20);
      if (accepted != `TX_FIFO_DEPTH) begin
         note_mismatch($sformatf("%0d writes taken at full depth", accepted));
      end
      if (wr_full !== 1'b1) note_mismatch("wr_full low after overfill");
      drain_fifo();
   endtask

   task automatic power_save_depth(input pwr_mode_e mode, input int depth);
      apply_reset(make_cfg(mode, 1'b0));
      write_words(12);
      if (accepted != depth) begin
         note_mismatch($sformatf("%0d writes taken, depth %0d", accepted, depth));
      end
      if (wr_full !== 1'b1) note_mismatch("wr_full low in power-save mode");
      drain_fifo();
   endtask

   task automatic empty_backpressure();
      apply_reset(make_cfg(PWR_FULL, 1'b0));
      write_words(2);
      drain_fifo();
      for (int i = 0; i < 6; i++) begin   // Pops on empty, all blocked
         @(negedge rd_clk);
         if (rd_empty !== 1'b1) note_mismatch("rd_empty fell with nothing written");
         rd_en = ~rd_en;
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
      write_words(3);
      drain_fifo();
   endtask

   task automatic double_write_pairs();
      apply_reset(make_cfg(PWR_FULL, 1'b1));
      write_words(7);
      if (accepted != 7) note_mismatch($sformatf("%0d of 7 pairs taken", accepted));
      if (wr_full !== 1'b0) note_mismatch("wr_full high at 14 words");
      drain_fifo();
      // Count steps 14 to 16, so the eighth pair passes the threshold
      write_words(9);
      if (accepted != 8) note_mismatch($sformatf("%0d pairs taken before full", accepted));
      if (wr_full !== 1'b1) note_mismatch("wr_full low at 16 words");
      drain_fifo();
   endtask

   task automatic interleaved_traffic();
      apply_reset(make_cfg(PWR_HALF, 1'b0));
      wr_done = 1'b0;
      fork
         begin
            for (int i = 0; i < 60; i++) begin
               @(negedge wr_clk);
               wr_data.lo = tx_word_t'($urandom);
               wr_data.hi = tx_word_t'($urandom);
               wr_en      = 1'($urandom % 2);
               if (wr_en && !(cfg.stop_write && wr_full)) exp_q.push_back(wr_data.lo);
            end
            @(negedge wr_clk);
            wr_en   = 1'b0;
            wr_done = 1'b1;
         end
         begin
            while (!wr_done) begin
               @(negedge rd_clk);
               rd_en = 1'($urandom % 2);
               if (!rd_empty && exp_q.size() == 0) begin
                  note_mismatch("rd_empty low with nothing outstanding");
               end
               else if (!rd_empty) begin
                  if (rd_data !== exp_q[0]) begin
                     note_mismatch($sformatf("rd_data %0h, expected %0h", rd_data, exp_q[0]));
                  end
                  if (rd_en) void'(exp_q.pop_front());
               end
            end
         end
      join
      drain_fifo();                       // Remaining words, in flight or stored
   endtask

   //*****************************************************************
   // Main sequence
   //*****************************************************************
   initial begin
      void'($urandom(32'h62bc_9694));
      mismatches = 0;
      failures   = 0;
      accepted   = 0;
      wr_done    = 1'b0;
      wr_rst_n   = 1'b0;
      rd_rst_n   = 1'b0;
      wr_en      = 1'b0;
      rd_en      = 1'b0;
      wr_data    = '0;
      cfg        = make_cfg(PWR_FULL, 1'b0);
      ordered_transfer();
      full_backpressure();
      power_save_depth(PWR_QUARTER, `TX_FIFO_PS_DEPTH);
      power_save_depth(PWR_HALF, 2 * `TX_FIFO_PS_DEPTH);
      empty_backpressure();
      double_write_pairs();
      interleaved_traffic();
      $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("=== PASS ===");
      end
      else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/tx_fifo_pkg.sv
verilog/cdc_bitsync2.sv
verilog/tx_fifo_pointers.sv
verilog/tx_fifo_flags.sv
verilog/tx_fifo_mem.sv
verilog/tx_fifo_top.sv
test/tb_tx_fifo.sv

// ==== Makefile ====
# Verilator build and run for the transmit dual-clock FIFO testbench

TOP := tb_tx_fifo

.PHONY: all lint clean

# Build, run, then pass only if the pass line was printed
all:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
